// File: hdl/tlb_config.svh
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

`define TLBNUM   8
`define TLB_IDXW 3
`define VPPN_W   19
`define PFN_W    20
`define ASID_W   10
`define PS_4K    12
`define PS_2M    21

// APB register map.
`define REG_IDX  8'h00
`define REG_EHI  8'h04
`define REG_ELO0 8'h08
`define REG_ELO1 8'h0C
`define REG_ASID 8'h10
`define REG_CMD  8'h14

`define CMD_WR   32'd1
`define CMD_RD   32'd2
`define CMD_INV  32'd3

`endif

// File: hdl/tlb_pkg.sv
`include "tlb_config.svh"

package tlb_pkg;

    // One page of the even/odd pair.
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [1:0]        mat;
        logic [1:0]        plv;
        logic              d;
        logic              v;
    } tlb_half_t;

    typedef struct packed {
        logic              e;       // Entry exists.
        logic [`VPPN_W-1:0] vppn;
        logic [5:0]        ps;
        logic              g;
        logic [`ASID_W-1:0] asid;
        tlb_half_t         half0;   // Even page.
        tlb_half_t         half1;   // Odd page.
    } tlb_entry_t;

endpackage

// File: hdl/tlb_entry_array.sv
`timescale 1ns/1ps
`include "tlb_config.svh"

module tlb_entry_array import tlb_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  logic                       rd_en,
    input  logic                       inv_en,
    input  logic [`TLB_IDXW-1:0]       wr_idx,
    input  tlb_entry_t                 wr_entry,
    output tlb_entry_t                 rd_entry,
    output tlb_entry_t [`TLBNUM-1:0]   entries
);

    tlb_entry_t [`TLBNUM-1:0] mem;
    logic [`TLBNUM-1:0]       valid;

    // Per-entry exist flags.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (inv_en) begin
            valid <= '0;                    // Clear-all.
        end else if (wr_en) begin
            valid[wr_idx] <= wr_entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < `TLBNUM; i++) begin
            entries[i]   = mem[i];
            entries[i].e = valid[i];        // Stored e is shadowed by the valid flop.
        end
    end

    // Read-back path, sampled into the staging registers on rd_en.
    assign rd_entry = entries[wr_idx];

endmodule

// File: hdl/tlb_match.sv
`timescale 1ns/1ps
`include "tlb_config.svh"

module tlb_match import tlb_pkg::*; (
    input  tlb_entry_t [`TLBNUM-1:0] entries,
    input  logic [`VPPN_W:0]         s_va,      // Virtual address bits 31:12.
    input  logic [`ASID_W-1:0]       s_asid,
    output logic [`TLBNUM-1:0]       found,
    output logic                     odd
);

    // Offset of the 2 MB odd bit inside s_va; also the number of vppn bits ignored.
    localparam int SHIFT_2M = `PS_2M - `PS_4K;

    logic [`TLBNUM-1:0] is_2m;
    logic [`TLBNUM-1:0] asid_ok;
    logic [`TLBNUM-1:0] vppn_ok;

    for (genvar i = 0; i < `TLBNUM; i++) begin : g_cmp
        assign is_2m[i]   = entries[i].ps == 6'(`PS_2M);
        assign asid_ok[i] = entries[i].g || (entries[i].asid == s_asid);

        // Large pages only compare the upper part of the page-pair number.
        assign vppn_ok[i] = is_2m[i]
            ? (entries[i].vppn[`VPPN_W-1:SHIFT_2M] == s_va[`VPPN_W:SHIFT_2M+1])
            : (entries[i].vppn == s_va[`VPPN_W:1]);

        assign found[i] = entries[i].e && asid_ok[i] && vppn_ok[i];
    end

    always_comb begin
        odd = s_va[0];                      // va[12] for 4 KB pages.
        for (int i = 0; i < `TLBNUM; i++) begin
            if (found[i] && is_2m[i]) begin
                odd = s_va[SHIFT_2M];       // va[21].
            end
        end
    end

endmodule

// File: hdl/tlb_found_signal.sv
`timescale 1ns/1ps
`include "tlb_config.svh"

module tlb_found_signal import tlb_pkg::*; (
    input  tlb_entry_t [`TLBNUM-1:0] entries,
    input  logic [`TLBNUM-1:0]       found0,
    input  logic                     odd0,
    input  logic [`TLBNUM-1:0]       found1,
    input  logic                     odd1,
    output logic                     found_v0,
    output logic                     found_v1,
    output logic                     found_d0,
    output logic                     found_d1,
    output logic [1:0]               found_mat0,
    output logic [1:0]               found_mat1,
    output logic [1:0]               found_plv0,
    output logic [1:0]               found_plv1,
    output logic [`PFN_W-1:0]        found_pfn0,
    output logic [`PFN_W-1:0]        found_pfn1,
    output logic [5:0]               found_ps0,
    output logic [5:0]               found_ps1
);

    // Zero unless hit is exactly one-hot.
    function automatic tlb_entry_t pick(input tlb_entry_t [`TLBNUM-1:0] ents,
                                       input logic [`TLBNUM-1:0] hit);
        tlb_entry_t r;
        r = '0;
        for (int i = 0; i < `TLBNUM; i++) begin
            if (hit == (`TLBNUM'(1) << i)) r = ents[i];
        end
        return r;
    endfunction

    tlb_entry_t sel0;
    tlb_entry_t sel1;
    tlb_half_t  pg0;
    tlb_half_t  pg1;

    always_comb begin
        sel0       = pick(entries, found0);
        pg0        = odd0 ? sel0.half1 : sel0.half0;
        found_ps0  = sel0.ps;
        found_v0   = pg0.v;
        found_d0   = pg0.d;
        found_mat0 = pg0.mat;
        found_plv0 = pg0.plv;
        found_pfn0 = pg0.pfn;
    end

    always_comb begin
        sel1       = pick(entries, found1);
        pg1        = odd1 ? sel1.half1 : sel1.half0;
        found_ps1  = sel1.ps;
        found_v1   = pg1.v;
        found_d1   = pg1.d;
        found_mat1 = pg1.mat;
        found_plv1 = pg1.plv;
        found_pfn1 = pg1.pfn;
    end

endmodule

// File: hdl/tlb_apb_regs.sv
`timescale 1ns/1ps
`include "tlb_config.svh"

module tlb_apb_regs import tlb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  tlb_entry_t           rd_entry,
    output logic                 wr_en,
    output logic                 rd_en,
    output logic                 inv_en,
    output logic [`TLB_IDXW-1:0] wr_idx,
    output tlb_entry_t           wr_entry
);

    logic                 access;
    logic                 wr_acc;
    logic                 cmd_wr;
    logic                 addr_ok;
    logic [31:0]          rdata;
    logic [`TLB_IDXW-1:0] idx_q;
    logic [`VPPN_W-1:0]   vppn_q;
    logic [5:0]           ps_q;
    logic [`ASID_W-1:0]   asid_q;
    tlb_half_t            lo0_q;
    tlb_half_t            lo1_q;
    logic                 g0_q;
    logic                 g1_q;

    function automatic logic [31:0] pack_lo(input tlb_half_t h, input logic g);
        return {4'b0, h.pfn, 1'b0, g, h.mat, h.plv, h.d, h.v};
    endfunction

    function automatic tlb_half_t unpack_lo(input logic [31:0] w);
        return '{pfn: w[27:8], mat: w[5:4], plv: w[3:2], d: w[1], v: w[0]};
    endfunction

    assign pready = 1'b1;                   // No wait states.
    assign access = psel && penable;
    assign wr_acc = access && pwrite;
    assign cmd_wr = wr_acc && (paddr == `REG_CMD);

    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (paddr)
            `REG_IDX:  rdata = 32'(idx_q);
            `REG_EHI:  rdata = {vppn_q, 7'b0, ps_q};
            `REG_ELO0: rdata = pack_lo(lo0_q, g0_q);
            `REG_ELO1: rdata = pack_lo(lo1_q, g1_q);
            `REG_ASID: rdata = 32'(asid_q);
            `REG_CMD:  rdata = '0;          // Commands are write-only.
            default:   addr_ok = 1'b0;
        endcase
        prdata  = (access && !pwrite) ? rdata : '0;
        pslverr = access && !addr_ok;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en  <= 1'b0;
            rd_en  <= 1'b0;
            inv_en <= 1'b0;
            idx_q  <= '0;
            vppn_q <= '0;
            ps_q   <= '0;
            asid_q <= '0;
            lo0_q  <= '0;
            lo1_q  <= '0;
            g0_q   <= 1'b0;
            g1_q   <= 1'b0;
        end else begin
            wr_en  <= cmd_wr && (pwdata == `CMD_WR);
            rd_en  <= cmd_wr && (pwdata == `CMD_RD);
            inv_en <= cmd_wr && (pwdata == `CMD_INV);
            if (wr_acc) begin
                case (paddr)
                    `REG_IDX:  idx_q <= pwdata[`TLB_IDXW-1:0];
                    `REG_EHI: begin
                        vppn_q <= pwdata[31:13];
                        ps_q   <= pwdata[5:0];
                    end
                    `REG_ELO0: begin
                        lo0_q <= unpack_lo(pwdata);
                        g0_q  <= pwdata[6];
                    end
                    `REG_ELO1: begin
                        lo1_q <= unpack_lo(pwdata);
                        g1_q  <= pwdata[6];
                    end
                    `REG_ASID: asid_q <= pwdata[`ASID_W-1:0];
                    default: ;
                endcase
            end
            // Entry read-back overwrites staging.
            if (rd_en) begin
                vppn_q <= rd_entry.vppn;
                ps_q   <= rd_entry.ps;
                asid_q <= rd_entry.asid;
                lo0_q  <= rd_entry.half0;
                lo1_q  <= rd_entry.half1;
                g0_q   <= rd_entry.g;
                g1_q   <= rd_entry.g;
            end
        end
    end

    assign wr_idx   = idx_q;
    assign wr_entry = '{e: 1'b1, vppn: vppn_q, ps: ps_q, g: g0_q & g1_q,
                        asid: asid_q, half0: lo0_q, half1: lo1_q};

endmodule

// File: hdl/tlb_top.sv
`timescale 1ns/1ps
`include "tlb_config.svh"

module tlb_top import tlb_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic [`VPPN_W:0]    s0_va,      // va[31:12], fetch.
    input  logic [`ASID_W-1:0]  s0_asid,
    input  logic [`VPPN_W:0]    s1_va,      // va[31:12], load/store.
    input  logic [`ASID_W-1:0]  s1_asid,
    output logic                s0_found,
    output logic [`PFN_W-1:0]   s0_pfn,
    output logic [1:0]          s0_mat,
    output logic [1:0]          s0_plv,
    output logic                s0_d,
    output logic                s0_v,
    output logic [5:0]          s0_ps,
    output logic                s1_found,
    output logic [`PFN_W-1:0]   s1_pfn,
    output logic [1:0]          s1_mat,
    output logic [1:0]          s1_plv,
    output logic                s1_d,
    output logic                s1_v,
    output logic [5:0]          s1_ps
);

    logic                      wr_en;
    logic                      rd_en;
    logic                      inv_en;
    logic [`TLB_IDXW-1:0]      wr_idx;
    tlb_entry_t                wr_entry;
    tlb_entry_t                rd_entry;
    tlb_entry_t [`TLBNUM-1:0]  entries;
    logic [`TLBNUM-1:0]        found0;
    logic [`TLBNUM-1:0]        found1;
    logic                      odd0;
    logic                      odd1;

    tlb_apb_regs u_regs (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .rd_entry(rd_entry), .wr_en(wr_en), .rd_en(rd_en), .inv_en(inv_en),
        .wr_idx(wr_idx), .wr_entry(wr_entry)
    );

    tlb_entry_array u_array (
        .clk(clk), .rst(rst), .wr_en(wr_en), .rd_en(rd_en), .inv_en(inv_en),
        .wr_idx(wr_idx), .wr_entry(wr_entry), .rd_entry(rd_entry), .entries(entries)
    );

    tlb_match u_match0 (
        .entries(entries), .s_va(s0_va), .s_asid(s0_asid), .found(found0), .odd(odd0)
    );

    tlb_match u_match1 (
        .entries(entries), .s_va(s1_va), .s_asid(s1_asid), .found(found1), .odd(odd1)
    );

    tlb_found_signal u_sel (
        .entries(entries),
        .found0(found0), .odd0(odd0), .found1(found1), .odd1(odd1),
        .found_v0(s0_v), .found_v1(s1_v), .found_d0(s0_d), .found_d1(s1_d),
        .found_mat0(s0_mat), .found_mat1(s1_mat), .found_plv0(s0_plv), .found_plv1(s1_plv),
        .found_pfn0(s0_pfn), .found_pfn1(s1_pfn), .found_ps0(s0_ps), .found_ps1(s1_ps)
    );

    assign s0_found = |found0;
    assign s1_found = |found1;

endmodule

// File: tests/tlb_tb_model.svh
`ifndef TLB_TB_MODEL_SVH
`define TLB_TB_MODEL_SVH

// Shadow of the entry table, kept in step with every command sent.
tlb_entry_t shadow [`TLBNUM];

// ELO register layout for one page half.
function automatic logic [31:0] elo_word(input tlb_half_t h, input logic g);
    logic [31:0] w;
    w       = '0;
    w[0]    = h.v;
    w[1]    = h.d;
    w[3:2]  = h.plv;
    w[5:4]  = h.mat;
    w[6]    = g;
    w[27:8] = h.pfn;
    return w;
endfunction

// Expected {found, ps, pfn, mat, plv, d, v} for one lookup port.
function automatic logic [32:0] expect_lookup(input logic [`VPPN_W:0] va,
                                              input logic [`ASID_W-1:0] asid);
    int        hits;
    int        sel;
    logic      big;
    tlb_half_t h;
    hits = 0;
    sel  = 0;
    for (int i = 0; i < `TLBNUM; i++) begin
        big = shadow[i].ps == 6'(`PS_2M);
        if (shadow[i].e && (shadow[i].g || shadow[i].asid == asid) &&
            (big ? shadow[i].vppn[`VPPN_W-1:`PS_2M-`PS_4K] == va[`VPPN_W:`PS_2M-`PS_4K+1]
                 : shadow[i].vppn == va[`VPPN_W:1])) begin
            hits++;
            sel = i;
        end
    end
    if (hits != 1) begin
        return {hits != 0, 32'b0};          // Several hits give zero fields.
    end
    big = shadow[sel].ps == 6'(`PS_2M);
    // Odd page bit sits just above the page size.
    h = (big ? va[`PS_2M-`PS_4K] : va[0]) ? shadow[sel].half1 : shadow[sel].half0;
    return {1'b1, shadow[sel].ps, h.pfn, h.mat, h.plv, h.d, h.v};
endfunction

`endif

// File: tests/tlb_tb.sv
`timescale 1ns/1ps
`include "tlb_config.svh"

module tlb_tb import tlb_pkg::*; ();

    localparam int NUM_OPS = 108;           // APB transfers plus lookups.

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic [7:0]         paddr = '0;
    logic               psel = 1'b0;
    logic               penable = 1'b0;
    logic               pwrite = 1'b0;
    logic [31:0]        pwdata = '0;
    logic [`VPPN_W:0]   s0_va = '0;
    logic [`ASID_W-1:0] s0_asid = '0;
    logic [`VPPN_W:0]   s1_va = '0;
    logic [`ASID_W-1:0] s1_asid = '0;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    logic [32:0]        res0;               // {found, ps, pfn, mat, plv, d, v}.
    logic [32:0]        res1;
    integer             seed;
    logic [31:0]        r;
    logic [31:0]        rdata;
    logic               err;

    `include "tlb_tb_model.svh"

    tlb_top DUT (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .s0_va(s0_va), .s0_asid(s0_asid), .s1_va(s1_va), .s1_asid(s1_asid),
        .s0_found(res0[32]), .s0_ps(res0[31:26]), .s0_pfn(res0[25:6]),
        .s0_mat(res0[5:4]), .s0_plv(res0[3:2]), .s0_d(res0[1]), .s0_v(res0[0]),
        .s1_found(res1[32]), .s1_ps(res1[31:26]), .s1_pfn(res1[25:6]),
        .s1_mat(res1[5:4]), .s1_plv(res1[3:2]), .s1_d(res1[1]), .s1_v(res1[0])
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
            else stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    // Slave never stalls, and errors only show in an access phase.
    apb_resp: assert property (@(posedge clk) pready && (!pslverr || (psel && penable)))
        else stop_run("APB response seen outside an access phase, or pready dropped.");

    // One APB transfer. Read data and error are taken mid access phase.
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #5;
        paddr  = addr;
        pwrite = wr;
        pwdata = data;
        psel   = 1'b1;
        @(posedge clk);
        #5;
        penable = 1'b1;
        #20;
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_entry(input int idx, input logic [`VPPN_W-1:0] vpn, input logic [5:0] psz,
                               input logic glob, input logic [`ASID_W-1:0] asn);
        tlb_half_t h0;
        tlb_half_t h1;
        h0 = 26'($random(seed));
        h1 = 26'($random(seed));
        apb_xfer(1'b1, `REG_IDX, 32'(idx));
        apb_xfer(1'b1, `REG_EHI, (32'(vpn) << 13) | 32'(psz));
        apb_xfer(1'b1, `REG_ELO0, elo_word(h0, glob));
        apb_xfer(1'b1, `REG_ELO1, elo_word(h1, glob));
        apb_xfer(1'b1, `REG_ASID, 32'(asn));
        apb_xfer(1'b1, `REG_CMD, `CMD_WR);
        shadow[idx] = '{e: 1'b1, vppn: vpn, ps: psz, g: glob, asid: asn, half0: h0, half1: h1};
    endtask

    task automatic lookup(input string name, input logic [`VPPN_W:0] va0,
                          input logic [`ASID_W-1:0] asid0, input logic [`VPPN_W:0] va1,
                          input logic [`ASID_W-1:0] asid1);
        @(posedge clk);
        #5;
        s0_va   = va0;
        s0_asid = asid0;
        s1_va   = va1;
        s1_asid = asid1;
        #20;
        check_value({name, " port0"}, 64'(expect_lookup(va0, asid0)), 64'(res0));
        check_value({name, " port1"}, 64'(expect_lookup(va1, asid1)), 64'(res1));
    endtask

    initial begin
        int j;
        seed = 32'h8a75_873a;
        for (int i = 0; i < `TLBNUM; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        repeat (4) begin
            lookup("reset_miss", 20'($random(seed)), 10'($random(seed)),
                   20'($random(seed)), 10'($random(seed)));
        end

        // Low vppn bits carry the index, so all 4 KB entries differ.
        for (int i = 0; i < `TLBNUM; i++) begin
            r = $random(seed);
            write_entry(i, {1'b0, r[14:0], 3'(i)}, 6'(`PS_4K), r[15], r[25:16]);
        end
        for (int i = 0; i < `TLBNUM; i++) begin
            j = (i + 3) % `TLBNUM;
            for (int o = 0; o < 2; o++) begin
                lookup("4k_entries", {shadow[i].vppn, 1'(o)}, shadow[i].asid ^ {10{shadow[i].g}},
                       {shadow[j].vppn, 1'(1 - o)}, shadow[j].asid);
            end
        end

        write_entry(0, {10'h3FF, 9'h000}, 6'(`PS_2M), 1'b1, 10'h000);
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            lookup("2m_page", {10'h3FF, 1'(k), r[8:0]}, r[18:9],
                   {10'h3FF, 1'(1 - (k % 2)), r[27:19]}, r[31:22]);
        end
        write_entry(1, {1'b0, 15'h1234, 3'd1}, 6'(`PS_4K), 1'b0, 10'h155);
        lookup("asid_miss", {1'b0, 15'h1234, 3'd1, 1'b0}, 10'h2AA,
               {1'b0, 15'h1234, 3'd1, 1'b1}, 10'h2AA);
        lookup("asid_hit", {1'b0, 15'h1234, 3'd1, 1'b0}, 10'h155,
               {1'b0, 15'h1234, 3'd1, 1'b1}, 10'h155);

        // Entry 0 is global, entry 1 is not.
        for (int i = 0; i < 2; i++) begin
            apb_xfer(1'b1, `REG_IDX, 32'(i));
            apb_xfer(1'b1, `REG_CMD, `CMD_RD);
            apb_xfer(1'b0, `REG_EHI, '0);
            check_value("read_ehi", (64'(shadow[i].vppn) << 13) | 64'(shadow[i].ps),
                        64'({err, rdata}));
            apb_xfer(1'b0, `REG_ELO0, '0);
            check_value("read_elo0", 64'(elo_word(shadow[i].half0, shadow[i].g)), 64'({err, rdata}));
            apb_xfer(1'b0, `REG_ELO1, '0);
            check_value("read_elo1", 64'(elo_word(shadow[i].half1, shadow[i].g)), 64'({err, rdata}));
            apb_xfer(1'b0, `REG_ASID, '0);
            check_value("read_asid", 64'(shadow[i].asid), 64'({err, rdata}));
        end

        apb_xfer(1'b1, `REG_CMD, `CMD_INV);
        for (int i = 0; i < `TLBNUM; i++) begin
            shadow[i].e = 1'b0;
        end
        for (int i = 0; i < `TLBNUM; i++) begin
            lookup("inv_miss", {shadow[i].vppn, 1'b0}, shadow[i].asid,
                   {shadow[i].vppn, 1'b1}, shadow[i].asid);
        end
        apb_xfer(1'b0, 8'h18, '0);
        check_value("bad_addr", 64'({1'b1, 32'b0}), 64'({err, rdata}));

        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 10 + 100) @(posedge clk);
        stop_run("Timeout: the tests did not finish in time.");
    end

endmodule

// File: project.f
+incdir+hdl
+incdir+tests
hdl/tlb_pkg.sv
hdl/tlb_entry_array.sv
hdl/tlb_match.sv
hdl/tlb_found_signal.sv
hdl/tlb_apb_regs.sv
hdl/tlb_top.sv
tests/tlb_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tlb_tb -o tlb_sim &&
    ./obj_dir/tlb_sim > sim.log 2>&1 || echo "Build or simulation stopped with an error."
grep -qs '^>>> PASS$' sim.log && echo "Simulation passed." || { echo "Simulation failed."; exit 1; }
